// File: calc_params.svh
// Calculator widths, radix and multiplier iteration count
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// Sign-magnitude word, sign in the top bit
`define CALC_WIDTH 16
`define CALC_MAG_WIDTH 15

// Keypad digit and operator code
`define CALC_DIGIT_WIDTH 4
`define CALC_OP_WIDTH 3

// Decimal entry
`define CALC_RADIX 10

// One shift-and-add step per magnitude bit
`define CALC_MULT_STEPS 15

`endif

// File: calc_pkg.sv
// Calculator types: words, digits, operator codes, controller states and unit requests
`default_nettype none
`include "calc_params.svh"

package calc_pkg;

    typedef logic [`CALC_WIDTH-1:0] word_t;
    typedef logic [`CALC_MAG_WIDTH-1:0] mag_t;
    typedef logic [`CALC_DIGIT_WIDTH-1:0] digit_t;

    typedef enum logic [`CALC_OP_WIDTH-1:0] {
        OP_NONE = 'd0,
        OP_NEG  = 'd1,
        OP_ADD  = 'd2,
        OP_SUB  = 'd3,
        OP_MUL  = 'd4
    } op_t;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_INPUT_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_INPUT_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT
    } gencon_state_t;

    typedef struct packed {
        word_t a;
        word_t b;
        logic  sub;
    } add_req_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } mult_req_t;

endpackage

`default_nettype wire

// File: sm_adder.sv
// Two-cycle sign-magnitude adder and subtractor with start and finish pulses
`timescale 1ns/1ps
`default_nettype none
`include "calc_params.svh"

module sm_adder (
    input  wire                      clk,
    input  wire                      nRST,
    input  wire calc_pkg::add_req_t  add_req,
    input  wire                      add_start,
    output calc_pkg::word_t          add_result,
    output logic                     add_finish
);

    logic           stage_vld;
    logic           sign_a, sign_b, a_ge_b;
    calc_pkg::mag_t mag_a, mag_b;

    logic           sign_sum;
    calc_pkg::mag_t mag_sum;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            stage_vld <= 1'b0;
            add_finish <= 1'b0;
        end else begin
            stage_vld <= add_start;
            add_finish <= stage_vld;
        end
    end

    // Cycle one flips b for subtract and compares magnitudes
    always_ff @(posedge clk) begin
        if (add_start) begin
            sign_a <= add_req.a[`CALC_WIDTH-1];
            sign_b <= add_req.b[`CALC_WIDTH-1] ^ add_req.sub;
            mag_a <= add_req.a[`CALC_MAG_WIDTH-1:0];
            mag_b <= add_req.b[`CALC_MAG_WIDTH-1:0];
            a_ge_b <= add_req.a[`CALC_MAG_WIDTH-1:0] >= add_req.b[`CALC_MAG_WIDTH-1:0];
        end
        if (stage_vld) begin
            add_result <= {sign_sum, mag_sum};
        end
    end

    always_comb begin
        if (sign_a == sign_b) begin
            mag_sum = mag_a + mag_b;
            sign_sum = sign_a;
        end else if (a_ge_b) begin
            mag_sum = mag_a - mag_b;
            sign_sum = sign_a;
        end else begin
            mag_sum = mag_b - mag_a;
            sign_sum = sign_b;
        end
        // No negative zero
        if (mag_sum == '0) begin
            sign_sum = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: shift_multiplier.sv
// Sequential sign-magnitude shift-and-add multiplier, product kept modulo 2^15
`timescale 1ns/1ps
`default_nettype none
`include "calc_params.svh"

module shift_multiplier (
    input  wire                       clk,
    input  wire                       nRST,
    input  wire calc_pkg::mult_req_t  mult_req,
    input  wire                       mult_start,
    output calc_pkg::word_t           mult_result,
    output logic                      mult_finish
);

    localparam int STEP_W = $clog2(`CALC_MULT_STEPS + 1);

    logic              busy, last_step, sign_q;
    logic [STEP_W-1:0] step;
    calc_pkg::mag_t    mag_a, mag_b;
    calc_pkg::mag_t    acc, mcand, mplier;

    assign mag_a = mult_req.a[`CALC_MAG_WIDTH-1:0];
    assign mag_b = mult_req.b[`CALC_MAG_WIDTH-1:0];
    assign last_step = (step == STEP_W'(`CALC_MULT_STEPS));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            step <= '0;
            mult_finish <= 1'b0;
        end else begin
            mult_finish <= 1'b0;
            if (mult_start) begin
                busy <= 1'b1;
                step <= STEP_W'(1);
            end else if (busy) begin
                if (last_step) begin
                    busy <= 1'b0;
                    mult_finish <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // Bit 0 is handled at load, bits 1..14 in the following steps
    always_ff @(posedge clk) begin
        if (mult_start) begin
            sign_q <= mult_req.a[`CALC_WIDTH-1] ^ mult_req.b[`CALC_WIDTH-1];
            acc <= mag_b[0] ? mag_a : '0;
            mcand <= mag_a << 1;
            mplier <= mag_b >> 1;
        end else if (busy) begin
            if (last_step) begin
                mult_result <= {sign_q && (acc != '0), acc};
            end else begin
                if (mplier[0]) begin
                    acc <= acc + mcand;
                end
                mcand <= mcand << 1;
                mplier <= mplier >> 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: gencon.sv
// Calculator entry controller: key decode, operand build-up, unit sequencing and display
`timescale 1ns/1ps
`default_nettype none
`include "calc_params.svh"

module gencon (
    input  wire                      clk,
    input  wire                      nRST,
    input  wire calc_pkg::digit_t    keypad_input,
    input  wire                      read_input,
    input  wire calc_pkg::op_t       operator_input,
    input  wire                      equal_input,
    output logic                     key_read,
    output logic                     complete,
    output calc_pkg::word_t          display_output,
    output calc_pkg::add_req_t       add_req,
    output logic                     add_start,
    input  wire calc_pkg::word_t     add_result,
    input  wire                      add_finish,
    output calc_pkg::mult_req_t      mult_req,
    output logic                     mult_start,
    input  wire calc_pkg::word_t     mult_result,
    input  wire                      mult_finish
);

    calc_pkg::gencon_state_t state, next_state;
    calc_pkg::word_t         operand1, operand2;
    calc_pkg::op_t           op_q;
    calc_pkg::digit_t        digit_q;

    // Previous key levels for edge detection
    logic                    prev_read, prev_equal;
    calc_pkg::op_t           prev_op;

    logic                    in_entry, op1_phase;
    logic                    rd_edge, op_edge, eq_edge;
    logic                    take_eq, take_digit, take_op, arith_op;
    logic                    exec_done;
    calc_pkg::mag_t          key_sum;
    calc_pkg::word_t         entry_operand, keyed_operand, exec_result;

    assign in_entry = (state == calc_pkg::WAIT_OP1) || (state == calc_pkg::WAIT_OP2);
    assign op1_phase = (state == calc_pkg::WAIT_OP1) || (state == calc_pkg::WAIT_MULT_OP1) ||
                       (state == calc_pkg::ADD_KEY_INPUT_OP1);

    assign rd_edge = read_input && !prev_read;
    assign op_edge = (operator_input != calc_pkg::OP_NONE) && (prev_op == calc_pkg::OP_NONE);
    assign eq_edge = equal_input && !prev_equal;

    // Only one key acted on per cycle, equal first
    assign take_eq = (state == calc_pkg::WAIT_OP2) && eq_edge;
    assign take_digit = in_entry && rd_edge && !take_eq;
    assign take_op = in_entry && op_edge && !take_digit && !take_eq;
    assign arith_op = operator_input inside {calc_pkg::OP_ADD, calc_pkg::OP_SUB, calc_pkg::OP_MUL};

    // Digit goes into the magnitude, sign is kept
    assign entry_operand = op1_phase ? operand1 : operand2;
    assign key_sum = entry_operand[`CALC_MAG_WIDTH-1:0] +
                     {{(`CALC_MAG_WIDTH-`CALC_DIGIT_WIDTH){1'b0}}, digit_q};
    assign keyed_operand = {entry_operand[`CALC_WIDTH-1], key_sum};

    assign exec_done = (op_q == calc_pkg::OP_MUL) ? mult_finish : add_finish;
    assign exec_result = (op_q == calc_pkg::OP_MUL) ? mult_result : add_result;

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::WAIT_OP1: begin
                if (take_digit) begin
                    next_state = calc_pkg::WAIT_MULT_OP1;
                end else if (take_op && arith_op) begin
                    next_state = calc_pkg::WAIT_OP2;
                end
            end
            calc_pkg::WAIT_MULT_OP1: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ADD_KEY_INPUT_OP1;
                end
            end
            calc_pkg::ADD_KEY_INPUT_OP1: next_state = calc_pkg::WAIT_OP1;
            calc_pkg::WAIT_OP2: begin
                if (take_eq) begin
                    next_state = calc_pkg::SEND_TO_COMPUTE;
                end else if (take_digit) begin
                    next_state = calc_pkg::WAIT_MULT_OP2;
                end
            end
            calc_pkg::WAIT_MULT_OP2: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ADD_KEY_INPUT_OP2;
                end
            end
            calc_pkg::ADD_KEY_INPUT_OP2: next_state = calc_pkg::WAIT_OP2;
            calc_pkg::SEND_TO_COMPUTE: next_state = calc_pkg::WAIT_COMPUTE;
            calc_pkg::WAIT_COMPUTE: begin
                if (exec_done) begin
                    next_state = calc_pkg::SHOW_RESULT;
                end
            end
            default: next_state = calc_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= calc_pkg::WAIT_OP1;
            operand1 <= '0;
            operand2 <= '0;
            op_q <= calc_pkg::OP_NONE;
            prev_read <= 1'b0;
            prev_op <= calc_pkg::OP_NONE;
            prev_equal <= 1'b0;
            key_read <= 1'b0;
            complete <= 1'b0;
            add_start <= 1'b0;
            mult_start <= 1'b0;
            display_output <= '0;
        end else begin
            state <= next_state;
            prev_read <= read_input;
            prev_op <= operator_input;
            prev_equal <= equal_input;
            key_read <= take_digit || take_op || take_eq;
            complete <= 1'b0;
            add_start <= 1'b0;
            mult_start <= take_digit;

            if (take_op && operator_input == calc_pkg::OP_NEG) begin
                if (op1_phase) begin
                    operand1[`CALC_WIDTH-1] <= 1'b1;
                end else begin
                    operand2[`CALC_WIDTH-1] <= 1'b1;
                end
            end
            // Second operator key while entering operand two is acknowledged only
            if (take_op && arith_op && state == calc_pkg::WAIT_OP1) begin
                op_q <= operator_input;
            end

            case (state)
                calc_pkg::WAIT_MULT_OP1: begin
                    if (mult_finish) begin
                        operand1 <= mult_result;
                    end
                end
                calc_pkg::WAIT_MULT_OP2: begin
                    if (mult_finish) begin
                        operand2 <= mult_result;
                    end
                end
                calc_pkg::ADD_KEY_INPUT_OP1: begin
                    operand1 <= keyed_operand;
                    display_output <= keyed_operand;
                end
                calc_pkg::ADD_KEY_INPUT_OP2: begin
                    operand2 <= keyed_operand;
                    display_output <= keyed_operand;
                end
                calc_pkg::SEND_TO_COMPUTE: begin
                    if (op_q == calc_pkg::OP_MUL) begin
                        mult_start <= 1'b1;
                    end else begin
                        add_start <= 1'b1;
                    end
                end
                calc_pkg::WAIT_COMPUTE: begin
                    // Result becomes operand one for chaining
                    if (exec_done) begin
                        operand1 <= exec_result;
                        operand2 <= '0;
                        display_output <= exec_result;
                        complete <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Unit requests, loaded together with their start pulse
    always_ff @(posedge clk) begin
        if (take_digit) begin
            digit_q <= keypad_input;
            mult_req.a <= entry_operand;
            mult_req.b <= calc_pkg::word_t'(`CALC_RADIX);
        end else if (state == calc_pkg::SEND_TO_COMPUTE) begin
            mult_req.a <= operand1;
            mult_req.b <= operand2;
        end
        if (state == calc_pkg::SEND_TO_COMPUTE) begin
            add_req.a <= operand1;
            add_req.b <= operand2;
            add_req.sub <= (op_q == calc_pkg::OP_SUB);
        end
    end

endmodule

`default_nettype wire

// File: calculator_top.sv
// Calculator core top level: entry controller with adder and multiplier units
`timescale 1ns/1ps
`default_nettype none

module calculator_top (
    input  wire                    clk,
    input  wire                    nRST,
    input  wire calc_pkg::digit_t  keypad_input,
    input  wire                    read_input,
    input  wire calc_pkg::op_t     operator_input,
    input  wire                    equal_input,
    output logic                   key_read,
    output logic                   complete,
    output calc_pkg::word_t        display_output
);

    calc_pkg::add_req_t  add_req;
    logic                add_start, add_finish;
    calc_pkg::word_t     add_result;

    calc_pkg::mult_req_t mult_req;
    logic                mult_start, mult_finish;
    calc_pkg::word_t     mult_result;

    gencon gencon_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output),
        .add_req        (add_req),
        .add_start      (add_start),
        .add_result     (add_result),
        .add_finish     (add_finish),
        .mult_req       (mult_req),
        .mult_start     (mult_start),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish)
    );

    sm_adder sm_adder_i (
        .clk        (clk),
        .nRST       (nRST),
        .add_req    (add_req),
        .add_start  (add_start),
        .add_result (add_result),
        .add_finish (add_finish)
    );

    // Shared by digit entry and the multiply operator
    shift_multiplier shift_multiplier_i (
        .clk         (clk),
        .nRST        (nRST),
        .mult_req    (mult_req),
        .mult_start  (mult_start),
        .mult_result (mult_result),
        .mult_finish (mult_finish)
    );

endmodule

`default_nettype wire

// File: calc_checker.sv
// Calculator checker: compares results and displayed operands against expected words
`timescale 1ns/1ps
`default_nettype none
`include "calc_params.svh"

module calc_checker (
    input  wire                   clk,
    input  wire                   nRST,
    input  wire                   key_read,
    input  wire                   complete,
    input  wire calc_pkg::word_t  display_output,
    input  wire calc_pkg::word_t  exp_result,
    input  wire                   exp_valid,
    input  wire calc_pkg::word_t  disp_exp,
    input  wire                   disp_check,
    output logic                  pending,
    output int                    errors,
    output int                    checks
);

    calc_pkg::word_t exp_q;
    int              wait_cycles;
    logic            in_reset;

    initial begin
        pending = 1'b0;
        errors = 0;
        checks = 0;
        wait_cycles = 0;
        in_reset = 1'b1;
        exp_q = '0;
    end

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!nRST) begin
            in_reset = 1'b1;
            pending = 1'b0;
        end else begin
            if (in_reset) begin
                in_reset = 1'b0;
                checks++;
                if (key_read !== 1'b0 || complete !== 1'b0 || display_output !== '0) begin
                    $display("[FAIL] %0t: after reset key_read=%b complete=%b display=0x%04h",
                             $time, key_read, complete, display_output);
                    errors++;
                end
            end
            if (complete) begin
                if (!pending) begin
                    $display("Unexpected complete pulse at time %0t with no equal key pending",
                             $time);
                    errors++;
                end else begin
                    checks++;
                    pending = 1'b0;
                    if (display_output !== exp_q) begin
                        $display("[FAIL] %0t: result 0x%04h, expected 0x%04h",
                                 $time, display_output, exp_q);
                        errors++;
                    end
                end
            end else if (pending) begin
                wait_cycles++;
                if (wait_cycles > 100) begin
                    $display("No complete pulse arrived within 100 cycles of the equal key");
                    errors++;
                    pending = 1'b0;
                end
            end
            if (exp_valid) begin
                exp_q = exp_result;
                pending = 1'b1;
                wait_cycles = 0;
            end
            if (disp_check) begin
                checks++;
                if (display_output !== disp_exp) begin
                    $display("[FAIL] %0t: operand on display 0x%04h, expected 0x%04h",
                             $time, display_output, disp_exp);
                    errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_calculator.sv
// Calculator testbench: vector file and random cases driven through the keypad interface
`timescale 1ns/1ps
`default_nettype none
`include "calc_params.svh"

module tb_calculator;

    localparam int MAG_MOD = 1 << `CALC_MAG_WIDTH;

    logic              clk, nRST;
    calc_pkg::digit_t  keypad_input;
    logic              read_input, equal_input;
    calc_pkg::op_t     operator_input;
    logic              key_read, complete;
    calc_pkg::word_t   display_output;

    calc_pkg::word_t   exp_result, disp_exp, last_result;
    logic              exp_valid, disp_check, pending, have_result;
    int                errors, checks, stim_errors, case_count;
    logic [31:0]       seed;

    calculator_top calculator_top_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_checker calc_checker_i (
        .clk            (clk),
        .nRST           (nRST),
        .key_read       (key_read),
        .complete       (complete),
        .display_output (display_output),
        .exp_result     (exp_result),
        .exp_valid      (exp_valid),
        .disp_exp       (disp_exp),
        .disp_check     (disp_check),
        .pending        (pending),
        .errors         (errors),
        .checks         (checks)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Reference arithmetic on signed integers, then folded back to sign-magnitude
    function automatic calc_pkg::word_t model_result(input calc_pkg::word_t a,
                                                     input calc_pkg::word_t b,
                                                     input calc_pkg::op_t op);
        int   va, vb, sum, mag;
        logic sign;
        va = int'(a[`CALC_MAG_WIDTH-1:0]);
        vb = int'(b[`CALC_MAG_WIDTH-1:0]);
        if (op == calc_pkg::OP_MUL) begin
            mag = (va * vb) % MAG_MOD;
            sign = a[`CALC_WIDTH-1] ^ b[`CALC_WIDTH-1];
        end else begin
            if (a[`CALC_WIDTH-1]) va = -va;
            if (b[`CALC_WIDTH-1] ^ (op == calc_pkg::OP_SUB)) vb = -vb;
            sum = va + vb;
            sign = sum < 0;
            mag = (sum < 0 ? -sum : sum) % MAG_MOD;
        end
        if (mag == 0) sign = 1'b0;
        return {sign, mag[`CALC_MAG_WIDTH-1:0]};
    endfunction

    task automatic apply_reset();
        nRST = 1'b0;
        read_input = 1'b0;
        equal_input = 1'b0;
        operator_input = calc_pkg::OP_NONE;
        repeat (10) @(posedge clk);
        #1;
        nRST = 1'b1;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic wait_key_ack(input string what);
        int   n;
        logic acked;
        n = 0;
        acked = 1'b0;
        while (!acked && n < 50) begin
            @(posedge clk);
            #1;
            n++;
            acked = key_read;
        end
        if (!acked) begin
            $display("The %s key was not acknowledged within 50 cycles", what);
            stim_errors++;
        end
    endtask

    task automatic idle_gap();
        repeat (25) @(posedge clk);
        #1;
    endtask

    task automatic press_digit(input int d);
        keypad_input = calc_pkg::digit_t'(d);
        read_input = 1'b1;
        wait_key_ack("digit");
        read_input = 1'b0;
        idle_gap();
    endtask

    task automatic press_op(input calc_pkg::op_t op);
        operator_input = op;
        wait_key_ack("operator");
        operator_input = calc_pkg::OP_NONE;
        idle_gap();
    endtask

    task automatic press_equal();
        equal_input = 1'b1;
        wait_key_ack("equal");
        equal_input = 1'b0;
        idle_gap();
    endtask

    task automatic check_display(input calc_pkg::word_t v);
        disp_exp = v;
        disp_check = 1'b1;
        @(posedge clk);
        #1;
        disp_check = 1'b0;
    endtask

    task automatic arm_result(input calc_pkg::word_t v);
        exp_result = v;
        exp_valid = 1'b1;
        @(posedge clk);
        #1;
        exp_valid = 1'b0;
    endtask

    // Decimal digits, most significant first; display follows the running value
    task automatic enter_operand(input int v, output calc_pkg::mag_t entered);
        string s;
        int    i, d, running;
        s = $sformatf("%0d", v);
        running = 0;
        for (i = 0; i < s.len(); i++) begin
            d = int'(s[i]) - 48;
            press_digit(d);
            running = (running * 10 + d) % MAG_MOD;
            check_display({1'b0, calc_pkg::mag_t'(running)});
        end
        entered = calc_pkg::mag_t'(running);
    endtask

    task automatic wait_result_checked();
        int n;
        n = 0;
        while (pending && n < 150) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending) begin
            $display("Result check still open 150 cycles after the equal key");
            stim_errors++;
        end
    endtask

    task automatic run_case(input bit chain, input int a_val, input bit a_neg,
                            input calc_pkg::op_t op, input int b_val, input bit b_neg,
                            input bit from_file, input calc_pkg::word_t file_exp);
        calc_pkg::mag_t  a_mag, b_mag;
        calc_pkg::word_t a_word, b_word, expected;
        if (chain) begin
            a_word = last_result;
        end else begin
            apply_reset();
            enter_operand(a_val, a_mag);
            a_word = {a_neg, a_mag};
            if (a_neg) press_op(calc_pkg::OP_NEG);
        end
        press_op(op);
        enter_operand(b_val, b_mag);
        b_word = {b_neg, b_mag};
        if (b_neg) press_op(calc_pkg::OP_NEG);
        expected = from_file ? file_exp : model_result(a_word, b_word, op);
        arm_result(expected);
        press_equal();
        wait_result_checked();
        last_result = expected;
        have_result = 1'b1;
        case_count++;
    endtask

    task automatic run_vector_file();
        int               fd, n, chain, a_val, a_neg, op_code, b_val, b_neg;
        logic [15:0]      exp_word;
        logic [8*120-1:0] line;
        fd = $fopen("calc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open calc_vectors.txt");
            stim_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %d %d %d %d %h",
                            chain, a_val, a_neg, op_code, b_val, b_neg, exp_word);
                if (n == 7) begin
                    run_case(chain != 0, a_val, a_neg != 0, calc_pkg::op_t'(op_code),
                             b_val, b_neg != 0, 1'b1, exp_word);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_random_cases(input int count);
        int            k, a_val, b_val, op_code;
        bit            a_neg, b_neg, chain;
        for (k = 0; k < count; k++) begin
            seed = lcg_next(seed);
            a_val = int'((seed >> 8) % 32'd10000);
            a_neg = seed[29];
            chain = have_result && (seed[31:30] == 2'b00);
            seed = lcg_next(seed);
            b_val = int'((seed >> 8) % 32'd10000);
            b_neg = seed[29];
            op_code = 2 + int'(seed[31:30]) % 3;
            run_case(chain, a_val, a_neg, calc_pkg::op_t'(op_code), b_val, b_neg, 1'b0, '0);
        end
    endtask

    initial begin
        clk = 1'b0;
        nRST = 1'b0;
        keypad_input = '0;
        read_input = 1'b0;
        operator_input = calc_pkg::OP_NONE;
        equal_input = 1'b0;
        exp_result = '0;
        exp_valid = 1'b0;
        disp_exp = '0;
        disp_check = 1'b0;
        last_result = '0;
        have_result = 1'b0;
        stim_errors = 0;
        case_count = 0;
        seed = 32'h1b97_f4f8;
        apply_reset();
        run_vector_file();
        run_random_cases(12);
        repeat (5) @(posedge clk);
        $display("Cases %0d, checks %0d, checker errors %0d, stimulus errors %0d",
                 case_count, checks, errors, stim_errors);
        if (errors == 0 && stim_errors == 0 && case_count > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: calc_vectors.txt
# chain a a_neg op b b_neg expected_hex  (op: 2 add, 3 sub, 4 mul)
# chain=1 skips reset and operand a, the last result is operand a
0 12 0 2 30 0 002A
0 12 1 2 30 0 0012
0 12 0 2 30 1 8012
0 12 1 2 30 1 802A
0 250 0 3 75 0 00AF
0 75 0 3 250 0 80AF
0 250 1 3 75 1 80AF
0 100 0 3 100 0 0000
0 100 1 2 100 0 0000
0 20000 0 2 20000 0 1C40
0 20000 1 2 20000 1 9C40
0 123 0 4 45 0 159F
0 123 1 4 45 0 959F
0 123 1 4 45 1 159F
0 300 0 4 200 0 6A60
0 0 0 4 99 1 0000
0 40000 0 2 1 0 1C41
1 0 0 2 7 0 1C48
1 0 0 4 3 1 D4D8
1 0 0 3 21720 1 0000
1 0 0 2 5 1 8005

// File: all.f
+incdir+.
calc_pkg.sv
sm_adder.sv
shift_multiplier.sv
gencon.sv
calculator_top.sv
calc_checker.sv
tb_calculator.sv

// File: Bender.yml
package:
  name: calculator

sources:
  - include_dirs:
      - .
    files:
      - calc_pkg.sv
      - sm_adder.sv
      - shift_multiplier.sv
      - gencon.sv
      - calculator_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - calc_checker.sv
      - tb_calculator.sv
